//--- hw/apb_bridge_pkg.sv
/*
 * Shared widths, codes and address map of the AHB-Lite to APB bridge.
 * RTL files refer to these by scoped names.
 */
package apb_bridge_pkg;

    // ##################################################################
    // Bus widths
    // ##################################################################
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;

    // ##################################################################
    // AHB codes
    // ##################################################################
    localparam int HTRANS_W = 2;

    localparam logic [2:0] HSIZE_BYTE = 3'd0;
    localparam logic [2:0] HSIZE_HALF = 3'd1;
    localparam logic [2:0] HSIZE_WORD = 3'd2;

    localparam logic [1:0] HRESP_OKAY  = 2'd0;
    localparam logic [1:0] HRESP_ERROR = 2'd1;

    // ##################################################################
    // APB address map
    // ##################################################################
    localparam int NUM_SLAVES  = 4;
    localparam int SLV_IDX_W   = 2;        // log2 of NUM_SLAVES.
    localparam int REGION_BITS = 12;       // 4 KB per slave.

    // Slave k sits at MAP_BASE + k * 4 KB.
    localparam addr_t MAP_BASE = 32'h4000_0000;

endpackage

//--- hw/ahb_req_capture.sv
/*
 * AHB-Lite side of the bridge. Accepts single transfers, registers the
 * request for the APB sequencer and returns hreadyout, hresp and hrdata
 * when the sequencer reports the end of the transfer.
 */
`timescale 1ns/1ps

module ahb_req_capture
(
    input  logic                                  i_hclk,
    input  logic                                  i_hrst_n,
    input  logic                                  i_hsel,
    input  logic                                  i_hreadyin,
    input  logic [apb_bridge_pkg::HTRANS_W-1:0]   i_htrans,
    input  apb_bridge_pkg::addr_t                 i_haddr,
    input  logic                                  i_hwrite,
    input  logic [2:0]                            i_hsize,
    input  apb_bridge_pkg::data_t                 i_hwdata,
    input  logic                                  i_xfer_done,
    input  logic                                  i_xfer_err,
    input  apb_bridge_pkg::data_t                 i_xfer_rdata,
    output logic                                  o_hreadyout,
    output logic [1:0]                            o_hresp,
    output apb_bridge_pkg::data_t                 o_hrdata,
    output logic                                  o_req_start,
    output apb_bridge_pkg::addr_t                 o_req_addr,
    output logic                                  o_req_write,
    output apb_bridge_pkg::strb_t                 o_req_strb,
    output apb_bridge_pkg::data_t                 o_req_wdata
);

    logic                  accept;
    apb_bridge_pkg::strb_t byte_en;

    // Only bit 1 of htrans separates NONSEQ/SEQ from IDLE/BUSY.
    assign accept = i_hsel & i_htrans[1] & i_hreadyin & o_hreadyout;

    // ##################################################################
    // Byte lanes from size and low address bits
    // ##################################################################
    always_comb
    begin
        byte_en = '0;                                      // Misaligned.
        case (i_hsize)
            apb_bridge_pkg::HSIZE_BYTE:
                byte_en = apb_bridge_pkg::strb_t'(4'b0001) << i_haddr[1:0];
            apb_bridge_pkg::HSIZE_HALF:
                if (!i_haddr[0])
                    byte_en = i_haddr[1] ? apb_bridge_pkg::strb_t'(4'b1100)
                                         : apb_bridge_pkg::strb_t'(4'b0011);
            apb_bridge_pkg::HSIZE_WORD:
                if (i_haddr[1:0] == 2'b00)
                    byte_en = '1;
            default:
                byte_en = '0;
        endcase
    end

    // ##################################################################
    // Handshake toward master and sequencer
    // ##################################################################
    always_ff @(posedge i_hclk or negedge i_hrst_n)
    begin
        if (!i_hrst_n)
        begin
            o_hreadyout <= 1'b1;
            o_hresp     <= apb_bridge_pkg::HRESP_OKAY;
            o_req_start <= 1'b0;
        end
        else
        begin
            o_req_start <= accept;                         // Data phase follows.
            if (accept)
                o_hreadyout <= 1'b0;
            else if (i_xfer_done)
                o_hreadyout <= 1'b1;
            // One cycle of ERROR alongside the rising hreadyout.
            o_hresp <= (i_xfer_done && i_xfer_err) ? apb_bridge_pkg::HRESP_ERROR
                                                   : apb_bridge_pkg::HRESP_OKAY;
        end
    end

    // Address phase fields.
    always_ff @(posedge i_hclk)
    begin
        if (accept)
        begin
            o_req_addr  <= i_haddr;
            o_req_write <= i_hwrite;
            o_req_strb  <= byte_en;
        end
    end

    always_ff @(posedge i_hclk)
    begin
        if (o_req_start)
            o_req_wdata <= i_hwdata;                       // Write data phase.
        if (i_xfer_done && !o_req_write)
            o_hrdata <= i_xfer_rdata;                      // Held until next read.
    end

    // The APB side only starts and finishes while the master is stalled.
    a_outstanding_stall : assert property (@(posedge i_hclk) disable iff (!i_hrst_n)
        (o_req_start || i_xfer_done) |-> !o_hreadyout);

endmodule

//--- hw/apb_phase_sequencer.sv
/*
 * APB phase state machine. Waits for a start from the AHB side, then runs
 * setup and access phases on the edges where the APB clock enable is high.
 */
`timescale 1ns/1ps

module apb_phase_sequencer
(
    input  logic                   i_hclk,
    input  logic                   i_hrst_n,
    input  logic                   i_pclk_en,
    input  logic                   i_req_start,
    input  logic                   i_pready,
    input  logic                   i_pslverr,
    input  apb_bridge_pkg::data_t  i_prdata,
    output logic                   o_psel,
    output logic                   o_penable,
    output logic                   o_xfer_done,
    output logic                   o_xfer_err,
    output apb_bridge_pkg::data_t  o_xfer_rdata
);

    typedef enum logic [1:0]
    {
        ST_IDLE   = 2'd0,
        ST_SETUP  = 2'd1,
        ST_ACCESS = 2'd2
    } state_t;

    state_t state;
    logic   pending;                                       // Start not yet served.
    logic   xfer_end;

    assign xfer_end  = (state == ST_ACCESS) & i_pready & i_pclk_en;

    assign o_psel    = (state != ST_IDLE);
    assign o_penable = (state == ST_ACCESS);

    // ##################################################################
    // Phase sequence
    // ##################################################################
    always_ff @(posedge i_hclk or negedge i_hrst_n)
    begin
        if (!i_hrst_n)
        begin
            state       <= ST_IDLE;
            pending     <= 1'b0;
            o_xfer_done <= 1'b0;
            o_xfer_err  <= 1'b0;
        end
        else
        begin
            o_xfer_done <= 1'b0;
            case (state)
                ST_IDLE:
                    if ((pending || i_req_start) && i_pclk_en)
                    begin
                        state   <= ST_SETUP;
                        pending <= 1'b0;
                    end
                    else if (i_req_start)
                        pending <= 1'b1;
                ST_SETUP:
                    if (i_pclk_en)
                        state <= ST_ACCESS;
                ST_ACCESS:
                    if (xfer_end)
                    begin
                        state       <= ST_IDLE;
                        o_xfer_done <= 1'b1;
                        o_xfer_err  <= i_pslverr;
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_hclk)
    begin
        if (xfer_end)
            o_xfer_rdata <= i_prdata;
    end

    // Access is always preceded by a setup cycle.
    a_setup_first : assert property (@(posedge i_hclk) disable iff (!i_hrst_n)
        o_penable |-> $past(o_psel));

    // The AHB side never starts a transfer on top of a running one.
    a_start_idle : assert property (@(posedge i_hclk) disable iff (!i_hrst_n)
        i_req_start |-> (state == ST_IDLE) && !pending);

endmodule

//--- hw/apb_slave_decode.sv
/*
 * Combinational APB decoder. Turns the shared address into one select per
 * 4 KB slave region and routes the selected slave's response back.
 */
`timescale 1ns/1ps

module apb_slave_decode
(
    input  logic                                                 i_psel,
    input  apb_bridge_pkg::addr_t                                i_paddr,
    input  logic [apb_bridge_pkg::NUM_SLAVES-1:0]                i_slv_pready,
    input  logic [apb_bridge_pkg::NUM_SLAVES-1:0]                i_slv_pslverr,
    input  logic [apb_bridge_pkg::NUM_SLAVES*apb_bridge_pkg::DATA_W-1:0] i_slv_prdata,
    output logic [apb_bridge_pkg::NUM_SLAVES-1:0]                o_slv_psel,
    output logic                                                 o_pready,
    output logic                                                 o_pslverr,
    output apb_bridge_pkg::data_t                                o_prdata
);

    localparam int WIN_LO = apb_bridge_pkg::REGION_BITS + apb_bridge_pkg::SLV_IDX_W;

    logic [apb_bridge_pkg::SLV_IDX_W-1:0] slv_idx;
    logic                                 hit;
    logic                                 unmapped;

    // Upper bits pick the window, the next bits pick the slave.
    assign hit      = (i_paddr[apb_bridge_pkg::ADDR_W-1:WIN_LO] ==
                       apb_bridge_pkg::MAP_BASE[apb_bridge_pkg::ADDR_W-1:WIN_LO]);
    assign slv_idx  = i_paddr[apb_bridge_pkg::REGION_BITS +: apb_bridge_pkg::SLV_IDX_W];
    assign unmapped = i_psel & ~hit;

    assign o_slv_psel = (i_psel && hit) ? (apb_bridge_pkg::NUM_SLAVES'(1) << slv_idx) : '0;

    // Unmapped access completes at once with an error.
    assign o_pready  = (|(o_slv_psel & i_slv_pready))  | unmapped;
    assign o_pslverr = (|(o_slv_psel & i_slv_pslverr)) | unmapped;
    assign o_prdata  = i_slv_prdata[slv_idx*apb_bridge_pkg::DATA_W +: apb_bridge_pkg::DATA_W];

    always_comb
    begin
        a_psel_onehot : assert ($onehot0(o_slv_psel) && (i_psel || o_slv_psel == '0))
            else $error("slave select not one-hot or active without psel");
    end

endmodule

//--- hw/ahb_apb_bridge_top.sv
/*
 * AHB-Lite to APB bridge with four 4 KB APB slaves.
 * i_pclk_en is high for one hclk cycle on every APB clock edge.
 */
`timescale 1ns/1ps

module ahb_apb_bridge_top
(
    input  logic                                                 i_hclk,
    input  logic                                                 i_hrst_n,
    input  logic                                                 i_pclk_en,
    // AHB-Lite slave port.
    input  logic                                                 i_hsel,
    input  logic                                                 i_hreadyin,
    input  apb_bridge_pkg::addr_t                                i_haddr,
    input  logic [apb_bridge_pkg::HTRANS_W-1:0]                  i_htrans,
    input  logic                                                 i_hwrite,
    input  logic [2:0]                                           i_hsize,
    input  apb_bridge_pkg::data_t                                i_hwdata,
    output logic                                                 o_hreadyout,
    output logic [1:0]                                           o_hresp,
    output apb_bridge_pkg::data_t                                o_hrdata,
    // APB master port.
    output logic [apb_bridge_pkg::NUM_SLAVES-1:0]                o_psel,
    output apb_bridge_pkg::addr_t                                o_paddr,
    output logic                                                 o_penable,
    output logic                                                 o_pwrite,
    output apb_bridge_pkg::data_t                                o_pwdata,
    output apb_bridge_pkg::strb_t                                o_pstrb,
    input  logic [apb_bridge_pkg::NUM_SLAVES-1:0]                i_pready,
    input  logic [apb_bridge_pkg::NUM_SLAVES-1:0]                i_pslverr,
    input  logic [apb_bridge_pkg::NUM_SLAVES*apb_bridge_pkg::DATA_W-1:0] i_prdata
);

    logic                  req_start;
    logic                  xfer_done;
    logic                  xfer_err;
    apb_bridge_pkg::data_t xfer_rdata;
    logic                  root_psel;
    logic                  root_pready;
    logic                  root_pslverr;
    apb_bridge_pkg::data_t root_prdata;

    ahb_req_capture u_capture
    (
        .i_hclk       (i_hclk),
        .i_hrst_n     (i_hrst_n),
        .i_hsel       (i_hsel),
        .i_hreadyin   (i_hreadyin),
        .i_htrans     (i_htrans),
        .i_haddr      (i_haddr),
        .i_hwrite     (i_hwrite),
        .i_hsize      (i_hsize),
        .i_hwdata     (i_hwdata),
        .i_xfer_done  (xfer_done),
        .i_xfer_err   (xfer_err),
        .i_xfer_rdata (xfer_rdata),
        .o_hreadyout  (o_hreadyout),
        .o_hresp      (o_hresp),
        .o_hrdata     (o_hrdata),
        .o_req_start  (req_start),
        .o_req_addr   (o_paddr),
        .o_req_write  (o_pwrite),
        .o_req_strb   (o_pstrb),
        .o_req_wdata  (o_pwdata)
    );

    apb_phase_sequencer u_sequencer
    (
        .i_hclk       (i_hclk),
        .i_hrst_n     (i_hrst_n),
        .i_pclk_en    (i_pclk_en),
        .i_req_start  (req_start),
        .i_pready     (root_pready),
        .i_pslverr    (root_pslverr),
        .i_prdata     (root_prdata),
        .o_psel       (root_psel),
        .o_penable    (o_penable),
        .o_xfer_done  (xfer_done),
        .o_xfer_err   (xfer_err),
        .o_xfer_rdata (xfer_rdata)
    );

    apb_slave_decode u_decode
    (
        .i_psel        (root_psel),
        .i_paddr       (o_paddr),
        .i_slv_pready  (i_pready),
        .i_slv_pslverr (i_pslverr),
        .i_slv_prdata  (i_prdata),
        .o_slv_psel    (o_psel),
        .o_pready      (root_pready),
        .o_pslverr     (root_pslverr),
        .o_prdata      (root_prdata)
    );

endmodule

//--- sim/tb_check_tasks.svh
/*
 * Compare tasks of the bridge testbench, one per kind of DUT result.
 * Included into tb_bridge; a mismatch stops the run at once.
 */

task automatic check_addr(input string name, input apb_bridge_pkg::addr_t got,
                          input apb_bridge_pkg::addr_t exp);
    if (got !== exp)
    begin
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_data(input string name, input apb_bridge_pkg::data_t got,
                          input apb_bridge_pkg::data_t exp);
    if (got !== exp)
    begin
        $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_strb(input string name, input apb_bridge_pkg::strb_t got,
                          input apb_bridge_pkg::strb_t exp);
    if (got !== exp)
    begin
        $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp)
    begin
        $display("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_sel(input string name, input logic [apb_bridge_pkg::NUM_SLAVES-1:0] got,
                         input logic [apb_bridge_pkg::NUM_SLAVES-1:0] exp);
    if (got !== exp)
    begin
        $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        stop_on_error();
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        stop_on_error();
    end
endtask

//--- sim/tb_bridge.sv
/*
 * Testbench of the AHB-Lite to APB bridge. Drives single AHB transfers into
 * four APB slave models with random clock enable and wait states, and checks
 * APB phases and AHB responses against a shadow memory.
 */
`timescale 1ns/1ps

module tb_bridge;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_RANDOM   = 48;
    localparam int WORDS        = 16;                      // Words modelled per slave.
    localparam int NUM_SLV      = apb_bridge_pkg::NUM_SLAVES;
    localparam int DW           = apb_bridge_pkg::DATA_W;

    typedef struct packed
    {
        logic                  write;
        logic [2:0]            size;
        apb_bridge_pkg::addr_t addr;
        apb_bridge_pkg::data_t wdata;
    } xfer_t;

    logic                  clk;
    logic                  rst_n;
    logic                  pclk_en;
    logic                  hsel;
    logic                  hreadyin;
    apb_bridge_pkg::addr_t haddr;
    logic [1:0]            htrans;
    logic                  hwrite;
    logic [2:0]            hsize;
    apb_bridge_pkg::data_t hwdata;
    logic                  hreadyout;
    logic [1:0]            hresp;
    apb_bridge_pkg::data_t hrdata;
    logic [NUM_SLV-1:0]    psel;
    apb_bridge_pkg::addr_t paddr;
    logic                  penable;
    logic                  pwrite;
    apb_bridge_pkg::data_t pwdata;
    apb_bridge_pkg::strb_t pstrb;
    logic [NUM_SLV-1:0]    slv_pready;
    logic [NUM_SLV-1:0]    slv_pslverr;
    logic [NUM_SLV*DW-1:0] slv_prdata;

    apb_bridge_pkg::data_t slv_mem [NUM_SLV][WORDS];
    apb_bridge_pkg::data_t shadow  [NUM_SLV][WORDS];
    logic [1:0]            wait_cnt [NUM_SLV];
    logic [NUM_SLV-1:0]    armed;
    logic [15:0]           lfsr_q;
    xfer_t                 stim_q [$];
    xfer_t                 pend_q [$];
    int                    done_cnt;
    int                    cycle_cnt;
    int                    cycle_limit;
    logic                  prev_ready;

    ahb_apb_bridge_top uut
    (
        .i_hclk      (clk),
        .i_hrst_n    (rst_n),
        .i_pclk_en   (pclk_en),
        .i_hsel      (hsel),
        .i_hreadyin  (hreadyin),
        .i_haddr     (haddr),
        .i_htrans    (htrans),
        .i_hwrite    (hwrite),
        .i_hsize     (hsize),
        .i_hwdata    (hwdata),
        .o_hreadyout (hreadyout),
        .o_hresp     (hresp),
        .o_hrdata    (hrdata),
        .o_psel      (psel),
        .o_paddr     (paddr),
        .o_penable   (penable),
        .o_pwrite    (pwrite),
        .o_pwdata    (pwdata),
        .o_pstrb     (pstrb),
        .i_pready    (slv_pready),
        .i_pslverr   (slv_pslverr),
        .i_prdata    (slv_prdata)
    );

    always #2 clk = ~clk;

    // ##################################################################
    // Reference model
    // ##################################################################
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11.
    endfunction

    function automatic apb_bridge_pkg::data_t fill_word(input int k, input int i);
        apb_bridge_pkg::addr_t a;
        a = apb_bridge_pkg::MAP_BASE + (k << apb_bridge_pkg::REGION_BITS) + (i << 2);
        return a ^ 32'h6C1B_93E5;
    endfunction

    function automatic logic is_mapped(input apb_bridge_pkg::addr_t a);
        return (a >= apb_bridge_pkg::MAP_BASE) &&
               (a < apb_bridge_pkg::MAP_BASE + (NUM_SLV << apb_bridge_pkg::REGION_BITS));
    endfunction

    function automatic int slave_of(input apb_bridge_pkg::addr_t a);
        return int'((a - apb_bridge_pkg::MAP_BASE) >> apb_bridge_pkg::REGION_BITS);
    endfunction

    function automatic logic [NUM_SLV-1:0] ref_sel(input apb_bridge_pkg::addr_t a);
        logic [NUM_SLV-1:0] sel;
        sel = '0;
        if (is_mapped(a))
            sel[slave_of(a)] = 1'b1;
        return sel;
    endfunction

    // Lanes of a naturally aligned transfer, none when misaligned.
    function automatic apb_bridge_pkg::strb_t ref_strb(input logic [2:0] size,
                                                        input apb_bridge_pkg::addr_t a);
        int nbytes;
        nbytes = 1 << size;
        if (size > 3'd2 || (a % nbytes) != 0)
            return '0;
        return apb_bridge_pkg::strb_t'(((1 << nbytes) - 1) << a[1:0]);
    endfunction

    function automatic logic [1:0] ref_resp(input xfer_t t);
        if (!is_mapped(t.addr) || (slave_of(t.addr) == NUM_SLV - 1 && t.write))
            return apb_bridge_pkg::HRESP_ERROR;
        return apb_bridge_pkg::HRESP_OKAY;
    endfunction

    function automatic apb_bridge_pkg::data_t merge_word(input apb_bridge_pkg::data_t old,
                                                          input apb_bridge_pkg::data_t wd,
                                                          input apb_bridge_pkg::strb_t strb);
        for (int b = 0; b < apb_bridge_pkg::STRB_W; b++)
            if (strb[b])
                old[8*b +: 8] = wd[8*b +: 8];
        return old;
    endfunction

    task automatic stop_on_error();
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at first error.");
    endtask

    `include "tb_check_tasks.svh"

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic add_xfer(input logic write, input logic [2:0] size,
                            input apb_bridge_pkg::addr_t addr);
        xfer_t       t;
        logic [31:0] d;
        draw_bits(32, d);
        t.write = write;
        t.size  = size;
        t.addr  = addr;
        t.wdata = d;
        stim_q.push_back(t);
    endtask

    task automatic add_random_xfer();
        logic [31:0]           w;
        logic [31:0]           r;
        logic [31:0]           u;
        logic [2:0]            sz;
        apb_bridge_pkg::addr_t a;
        draw_bits(1, w);
        draw_bits(8, r);                                   // Slave, word, byte offset.
        draw_bits(2, u);
        sz = (u[1:0] == 2'd3) ? apb_bridge_pkg::HSIZE_WORD : {1'b0, u[1:0]};
        draw_bits(3, u);
        if (u[2:0] == 3'd0)
            a = apb_bridge_pkg::MAP_BASE + 32'h0001_0000 + {26'd0, r[5:0]};  // Unmapped.
        else
            a = apb_bridge_pkg::MAP_BASE + {18'd0, r[7:6], 12'd0} + {26'd0, r[5:0]};
        add_xfer(w[0], sz, a);
    endtask

    // One AHB single transfer, from address phase to hreadyout high.
    task automatic run_xfer(input xfer_t t);
        hsel   = 1'b1;
        htrans = 2'b10;
        haddr  = t.addr;
        hwrite = t.write;
        hsize  = t.size;
        pend_q.push_back(t);
        @(negedge clk);
        hsel   = 1'b0;
        htrans = 2'b00;
        hwdata = t.wdata;
        while (!hreadyout)
            @(negedge clk);
    endtask

    // ##################################################################
    // APB slave models and clock enable
    // ##################################################################
    always @(negedge clk)
    begin
        logic [31:0] r;
        if (cycle_cnt <= RESET_CYCLES)
        begin
            pclk_en     = 1'b0;
            slv_pready  = '0;
            slv_pslverr = '0;
            armed       = '0;
        end
        else
        begin
            draw_bits(1, r);
            pclk_en = r[0];
            for (int k = 0; k < NUM_SLV; k++)
            begin
                slv_prdata[k*DW +: DW] = slv_mem[k][paddr[5:2]];
                slv_pslverr[k]         = (k == NUM_SLV - 1) && pwrite;  // Read-only.
                if (!psel[k])
                begin
                    slv_pready[k] = 1'b0;
                    armed[k]      = 1'b0;
                end
                else
                begin
                    if (!armed[k])
                    begin
                        draw_bits(2, r);
                        wait_cnt[k] = r[1:0];
                        armed[k]    = 1'b1;
                    end
                    if (wait_cnt[k] == 2'd0)
                        slv_pready[k] = 1'b1;
                    else
                    begin
                        slv_pready[k] = 1'b0;
                        wait_cnt[k]   = wait_cnt[k] - 2'd1;
                    end
                end
            end
        end
    end

    always @(posedge clk)
    begin
        if (rst_n && penable && pwrite && pclk_en)
            for (int k = 0; k < NUM_SLV - 1; k++)          // Last slave keeps its data.
                if (psel[k] && slv_pready[k])
                    for (int b = 0; b < apb_bridge_pkg::STRB_W; b++)
                        if (pstrb[b])
                            slv_mem[k][paddr[5:2]][8*b +: 8] <= pwdata[8*b +: 8];
    end

    // ##################################################################
    // Comparison and timeout
    // ##################################################################
    always @(negedge clk)
    begin
        xfer_t t;
        if (cycle_cnt > RESET_CYCLES)
        begin
            if ((|psel || penable) && pend_q.size() == 0)
            begin
                $display("APB activity at %0t ns with no transfer outstanding", $time);
                stop_on_error();
            end
            if (pend_q.size() != 0)
            begin
                t = pend_q[0];
                if (|psel)
                    check_sel("o_psel", psel, ref_sel(t.addr));
                if (penable && is_mapped(t.addr) && psel == '0)
                begin
                    $display("o_penable high without a slave select at %0t ns", $time);
                    stop_on_error();
                end
                if (penable)
                begin
                    check_addr("o_paddr", paddr, t.addr);
                    check_flag("o_pwrite", pwrite, t.write);
                    if (t.write)
                    begin
                        check_strb("o_pstrb", pstrb, ref_strb(t.size, t.addr));
                        check_data("o_pwdata", pwdata, t.wdata);
                    end
                end
                if (hreadyout && !prev_ready)
                begin
                    void'(pend_q.pop_front());
                    check_resp("o_hresp", hresp, ref_resp(t));
                    if (ref_resp(t) == apb_bridge_pkg::HRESP_OKAY)
                    begin
                        if (t.write)
                            shadow[slave_of(t.addr)][t.addr[5:2]] =
                                merge_word(shadow[slave_of(t.addr)][t.addr[5:2]],
                                           t.wdata, ref_strb(t.size, t.addr));
                        else
                            check_data("o_hrdata", hrdata,
                                       shadow[slave_of(t.addr)][t.addr[5:2]]);
                    end
                    done_cnt++;
                end
            end
            prev_ready = hreadyout;
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
        begin
            $display("Timeout, transfers not finished within %0d cycles", cycle_limit);
            stop_on_error();
        end
    end

    // ##################################################################
    // Test sequence
    // ##################################################################
    initial
    begin
        apb_bridge_pkg::addr_t base;
        clk         = 1'b0;
        rst_n       = 1'b0;
        pclk_en     = 1'b0;
        hsel        = 1'b0;
        hreadyin    = 1'b1;
        haddr       = '0;
        htrans      = 2'b00;
        hwrite      = 1'b0;
        hsize       = 3'd0;
        hwdata      = '0;
        slv_pready  = '0;
        slv_pslverr = '0;
        slv_prdata  = '0;
        armed       = '0;
        lfsr_q      = 16'd68;
        done_cnt    = 0;
        cycle_cnt   = 0;
        prev_ready  = 1'b1;
        for (int k = 0; k < NUM_SLV; k++)
            for (int i = 0; i < WORDS; i++)
            begin
                slv_mem[k][i] = fill_word(k, i);
                shadow[k][i]  = fill_word(k, i);
            end

        // Sub-word writes merged into two words, then read back.
        for (int k = 0; k < NUM_SLV - 1; k++)
        begin
            base = apb_bridge_pkg::MAP_BASE + (k << apb_bridge_pkg::REGION_BITS);
            add_xfer(1'b1, apb_bridge_pkg::HSIZE_WORD, base);
            add_xfer(1'b1, apb_bridge_pkg::HSIZE_BYTE, base + 32'd1);
            add_xfer(1'b1, apb_bridge_pkg::HSIZE_HALF, base + 32'd6);
            add_xfer(1'b1, apb_bridge_pkg::HSIZE_BYTE, base + 32'd7);
            add_xfer(1'b1, apb_bridge_pkg::HSIZE_HALF, base + 32'd3);   // Misaligned.
            add_xfer(1'b0, apb_bridge_pkg::HSIZE_WORD, base);
            add_xfer(1'b0, apb_bridge_pkg::HSIZE_WORD, base + 32'd4);
        end
        add_xfer(1'b1, apb_bridge_pkg::HSIZE_WORD, apb_bridge_pkg::MAP_BASE + 32'h4000);
        add_xfer(1'b0, apb_bridge_pkg::HSIZE_WORD, apb_bridge_pkg::MAP_BASE - 32'h1000);
        add_xfer(1'b1, apb_bridge_pkg::HSIZE_WORD, apb_bridge_pkg::MAP_BASE + 32'h3008);
        add_xfer(1'b0, apb_bridge_pkg::HSIZE_WORD, apb_bridge_pkg::MAP_BASE + 32'h3008);
        for (int n = 0; n < NUM_RANDOM; n++)
            add_random_xfer();
        cycle_limit = stim_q.size() * 64 + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("o_hreadyout", hreadyout, 1'b1);
        check_resp("o_hresp", hresp, apb_bridge_pkg::HRESP_OKAY);
        check_sel("o_psel", psel, '0);
        check_flag("o_penable", penable, 1'b0);

        foreach (stim_q[n])
            run_xfer(stim_q[n]);
        repeat (2) @(negedge clk);

        if (done_cnt == stim_q.size() && pend_q.size() == 0)
        begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else
        begin
            $display("Only %0d of %0d transfers completed", done_cnt, stim_q.size());
            stop_on_error();
        end
    end

endmodule

//--- verilog.f
+incdir+sim
hw/apb_bridge_pkg.sv
hw/ahb_req_capture.sv
hw/apb_phase_sequencer.sv
hw/apb_slave_decode.sv
hw/ahb_apb_bridge_top.sv
sim/tb_bridge.sv

//--- Makefile
# Verilator build, run and lint of the AHB-Lite to APB bridge.
# Any variable can be overridden, e.g. make LOG=run.log

VERILATOR  ?= verilator
TOP        ?= tb_bridge
RTL_TOP    ?= ahb_apb_bridge_top
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, not the exit code of the simulation.
run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "Result: FAIL"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then echo "Result: no pass line"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
